// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_px_ss
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS := build.f source/px_ss_config.svh $(wildcard source/*.sv) $(wildcard tests/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f build.f

run: $(BIN)
	./$(BIN) > $(LOG)
	@cat $(LOG)
	@grep -qx "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+source
source/px_ss_pkg.sv
source/px_ss_csr.sv
source/px_ss_in.sv
source/px_ss_skip.sv
source/px_ss_out.sv
source/px_ss_top.sv
tests/tb_px_ss.sv

// ==== source/px_ss_config.svh ====
`ifndef PX_SS_CONFIG_SVH
`define PX_SS_CONFIG_SVH

// ====================
// Stream
// ====================

`define PX_DATA_W  24 // Bits of pixel payload per beat

// ====================
// Register port
// ====================

`define CSR_ADDR_W 32 // AXI4-Lite byte address width

`endif

// ==== source/px_ss_csr.sv ====
`include "px_ss_config.svh"

module px_ss_csr #(
  parameter logic [31:0] BASE_ADDR = 32'h0000_0000
)(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  px_ss_pkg::axil_req_t  csr_req_i,
  output px_ss_pkg::axil_rsp_t  csr_rsp_o,
  output px_ss_pkg::px_ss_cfg_t cfg_o
);
  import px_ss_pkg::*;

  localparam int REG_CNT = 6;

  logic        aw_hs;
  logic        w_hs;
  logic        ar_hs;
  logic        b_hs;
  logic        r_hs;
  logic        aw_got;
  logic        w_got;
  logic        aw_just;
  logic        w_just;
  logic        backpressure;
  logic        wr_req;
  logic        wr_hit;
  logic        rd_pend;
  logic        bvalid_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic [31:0] wdata_q;
  logic [3:0]  wstrb_q;
  csr_addr_e   wr_idx;
  csr_addr_e   rd_idx;
  px_ss_cfg_t  cfg_q;

  function automatic logic addr_hit(input logic [`CSR_ADDR_W-1:0] addr);
    logic [`CSR_ADDR_W-1:0] offs;
    offs = addr - `CSR_ADDR_W'(BASE_ADDR);
    return (addr >= `CSR_ADDR_W'(BASE_ADDR)) && (offs[`CSR_ADDR_W-1:2] < REG_CNT);
  endfunction

  function automatic csr_addr_e addr_idx(input logic [`CSR_ADDR_W-1:0] addr);
    logic [`CSR_ADDR_W-1:0] offs;
    offs = addr - `CSR_ADDR_W'(BASE_ADDR);
    return csr_addr_e'(offs[4:2]);
  endfunction

  // Only the two low byte lanes exist in a 16-bit register
  function automatic logic [15:0] merge(input logic [15:0] old, input logic [31:0] data,
                                        input logic [3:0] strb);
    logic [15:0] res;
    res = old;
    if (strb[0])
      res[7:0] = data[7:0];
    if (strb[1])
      res[15:8] = data[15:8];
    return res;
  endfunction

  assign aw_hs        = csr_req_i.awvalid && csr_rsp_o.awready;
  assign w_hs         = csr_req_i.wvalid && csr_rsp_o.wready;
  assign ar_hs        = csr_req_i.arvalid && csr_rsp_o.arready;
  assign b_hs         = bvalid_q && csr_req_i.bready;
  assign r_hs         = rvalid_q && csr_req_i.rready;
  assign backpressure = aw_just ^ w_just; // One phase arrived without the other
  assign wr_req       = aw_got && w_got;

  // ====================
  // Write path
  // ====================

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      aw_just <= 1'b0;
      w_just  <= 1'b0;
    end
    else
    begin
      aw_just <= aw_hs;
      w_just  <= w_hs;
      if (wr_req)
      begin
        aw_got <= 1'b0;
        w_got  <= 1'b0;
      end
      else
      begin
        if (aw_hs)
          aw_got <= 1'b1;
        if (w_hs)
          w_got <= 1'b1;
      end
    end

  always_ff @(posedge clk_i)
  begin
    if (aw_hs)
    begin
      wr_hit <= addr_hit(csr_req_i.awaddr);
      wr_idx <= addr_idx(csr_req_i.awaddr);
    end
    if (w_hs)
    begin
      wdata_q <= csr_req_i.wdata;
      wstrb_q <= csr_req_i.wstrb;
    end
    if (ar_hs)
      rd_idx <= addr_idx(csr_req_i.araddr);
  end

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      cfg_q <= '0; // All zero means pass-through
    else if (wr_req && wr_hit)
      case (wr_idx)
        PS_PX_SKIP_CR:
          cfg_q.px_to_skip <= merge(cfg_q.px_to_skip, wdata_q, wstrb_q);
        PS_PX_INTERVAL_CR:
          cfg_q.px_skip_interval <= merge(cfg_q.px_skip_interval, wdata_q, wstrb_q);
        PS_PX_ADD_INTERVAL_CR:
          cfg_q.add_px_skip_interval <= merge(cfg_q.add_px_skip_interval, wdata_q, wstrb_q);
        PS_LN_SKIP_CR:
          cfg_q.ln_to_skip <= merge(cfg_q.ln_to_skip, wdata_q, wstrb_q);
        PS_LN_INTERVAL_CR:
          cfg_q.ln_skip_interval <= merge(cfg_q.ln_skip_interval, wdata_q, wstrb_q);
        PS_LN_ADD_INTERVAL_CR:
          cfg_q.add_ln_skip_interval <= merge(cfg_q.add_ln_skip_interval, wdata_q, wstrb_q);
        default: ;
      endcase

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      bvalid_q <= 1'b0;
    else if (wr_req && wr_hit)
      bvalid_q <= 1'b1;
    else if (b_hs)
      bvalid_q <= 1'b0;

  // ====================
  // Read path
  // ====================

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      rd_pend  <= 1'b0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      rd_pend <= ar_hs && addr_hit(csr_req_i.araddr); // Misses never answer
      if (rd_pend)
        rvalid_q <= 1'b1;
      else if (r_hs)
        rvalid_q <= 1'b0;
    end

  always_ff @(posedge clk_i)
    if (rd_pend)
      case (rd_idx)
        PS_PX_SKIP_CR:         rdata_q <= 32'(cfg_q.px_to_skip);
        PS_PX_INTERVAL_CR:     rdata_q <= 32'(cfg_q.px_skip_interval);
        PS_PX_ADD_INTERVAL_CR: rdata_q <= 32'(cfg_q.add_px_skip_interval);
        PS_LN_SKIP_CR:         rdata_q <= 32'(cfg_q.ln_to_skip);
        PS_LN_INTERVAL_CR:     rdata_q <= 32'(cfg_q.ln_skip_interval);
        PS_LN_ADD_INTERVAL_CR: rdata_q <= 32'(cfg_q.add_ln_skip_interval);
        default:               rdata_q <= 32'd0;
      endcase

  always_comb
  begin
    csr_rsp_o         = '0;
    csr_rsp_o.awready = !backpressure && !aw_got;
    csr_rsp_o.wready  = !backpressure && !w_got;
    csr_rsp_o.bvalid  = bvalid_q;
    csr_rsp_o.bresp   = 2'b00;
    csr_rsp_o.arready = 1'b1;
    csr_rsp_o.rvalid  = rvalid_q;
    csr_rsp_o.rdata   = rdata_q;
    csr_rsp_o.rresp   = 2'b00;
  end

  assign cfg_o = cfg_q;

endmodule

// ==== source/px_ss_in.sv ====
module px_ss_in (
  input  logic                clk_i,
  input  logic                rst_i,
  input  px_ss_pkg::px_beat_t in_beat_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  output px_ss_pkg::px_beat_t beat_o,
  output logic                valid_o,
  input  logic                ready_i
);
  import px_ss_pkg::*;

  px_beat_t main_q;
  px_beat_t skid_q;
  logic     main_valid;
  logic     skid_valid;
  logic     main_free;

  assign main_free = !main_valid || ready_i; // Main slot empties or moves on this cycle

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end
    else if (main_free)
    begin
      main_valid <= skid_valid || in_valid_i;
      skid_valid <= 1'b0;
    end
    else if (in_valid_i && !skid_valid)
      skid_valid <= 1'b1; // Stalled output, park the incoming beat

  always_ff @(posedge clk_i)
  begin
    if (main_free)
      main_q <= skid_valid ? skid_q : in_beat_i;
    if (!main_free && !skid_valid)
      skid_q <= in_beat_i;
  end

  // Ready comes straight from a flop so the source never sees later logic
  assign in_ready_o = !skid_valid;
  assign beat_o     = main_q;
  assign valid_o    = main_valid;

endmodule

// ==== source/px_ss_out.sv ====
module px_ss_out (
  input  logic                clk_i,
  input  logic                rst_i,
  input  px_ss_pkg::px_beat_t beat_i,
  input  logic                keep_i,
  input  logic                valid_i,
  output logic                ready_o,
  output px_ss_pkg::px_beat_t out_beat_o,
  output logic                out_valid_o,
  input  logic                out_ready_i
);
  import px_ss_pkg::*;

  typedef enum logic [1:0] {
    ST_EMPTY,
    ST_HOLD,
    ST_FLUSH // Held pixel closes a line and still has to go out
  } state_e;

  state_e   state_q;
  state_e   state_d;
  px_beat_t held_q;
  px_beat_t out_q;
  px_beat_t emit_beat;
  logic     out_valid_q;
  logic     sof_pend_q;
  logic     sof_eff;
  logic     out_free;
  logic     xfer;
  logic     emit;
  logic     load;

  assign out_free = !out_valid_q || out_ready_i;
  assign ready_o  = out_free && (state_q != ST_FLUSH);
  assign xfer     = valid_i && ready_o;
  assign sof_eff  = sof_pend_q || beat_i.sof; // Frame start carried over dropped beats

  always_comb
  begin
    state_d   = state_q;
    emit      = 1'b0;
    emit_beat = held_q;
    load      = 1'b0;
    case (state_q)
      ST_EMPTY:
        if (xfer && keep_i)
        begin
          if (beat_i.eol)
          begin
            emit      = 1'b1;
            emit_beat = '{data: beat_i.data, sof: sof_eff, eol: 1'b1};
          end
          else
          begin
            load    = 1'b1;
            state_d = ST_HOLD;
          end
        end
      ST_HOLD:
        if (xfer && keep_i)
        begin
          emit    = 1'b1;
          load    = 1'b1;
          state_d = beat_i.eol ? ST_FLUSH : ST_HOLD;
        end
        else if (xfer && beat_i.eol)
        begin
          emit          = 1'b1;
          emit_beat.eol = 1'b1;
          state_d       = ST_EMPTY;
        end
      ST_FLUSH:
        if (out_free)
        begin
          emit    = 1'b1;
          state_d = ST_EMPTY;
        end
      default: state_d = ST_EMPTY;
    endcase
  end

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      state_q     <= ST_EMPTY;
      out_valid_q <= 1'b0;
      sof_pend_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (emit)
        out_valid_q <= 1'b1;
      else if (out_ready_i)
        out_valid_q <= 1'b0;
      if (xfer)
        sof_pend_q <= keep_i ? 1'b0 : sof_eff;
    end

  always_ff @(posedge clk_i)
  begin
    if (emit)
      out_q <= emit_beat;
    if (load)
      held_q <= '{data: beat_i.data, sof: sof_eff, eol: beat_i.eol};
  end

  assign out_beat_o  = out_q;
  assign out_valid_o = out_valid_q;

endmodule

// ==== source/px_ss_pkg.sv ====
`include "px_ss_config.svh"

package px_ss_pkg;

  typedef struct packed {
    logic [`PX_DATA_W-1:0] data;
    logic                  sof;
    logic                  eol;
  } px_beat_t;

  typedef struct packed {
    logic [15:0] px_to_skip;
    logic [15:0] px_skip_interval;
    logic [15:0] add_px_skip_interval;
    logic [15:0] ln_to_skip;
    logic [15:0] ln_skip_interval;
    logic [15:0] add_ln_skip_interval;
  } px_ss_cfg_t;

  // Word index of each register above BASE_ADDR
  typedef enum logic [2:0] {
    PS_PX_SKIP_CR         = 3'd0,
    PS_PX_INTERVAL_CR     = 3'd1,
    PS_PX_ADD_INTERVAL_CR = 3'd2,
    PS_LN_SKIP_CR         = 3'd3,
    PS_LN_INTERVAL_CR     = 3'd4,
    PS_LN_ADD_INTERVAL_CR = 3'd5
  } csr_addr_e;

  typedef struct packed {
    logic [`CSR_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic [31:0]            wdata;
    logic [3:0]             wstrb;
    logic                   wvalid;
    logic                   bready;
    logic [`CSR_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

endpackage

// ==== source/px_ss_skip.sv ====
module px_ss_skip (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  px_ss_pkg::px_ss_cfg_t cfg_i,
  input  px_ss_pkg::px_beat_t   beat_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output px_ss_pkg::px_beat_t   beat_o,
  output logic                  keep_o,
  output logic                  valid_o,
  input  logic                  ready_i
);
  import px_ss_pkg::*;

  typedef struct packed {
    logic [15:0] pos; // Position inside the current period
    logic [15:0] per; // Period number modulo the add interval
  } cnt_t;

  cnt_t px_q;
  cnt_t ln_q;
  cnt_t px_cur;
  cnt_t ln_cur;
  logic xfer;
  logic px_drop;
  logic ln_drop;

  function automatic cnt_t advance(input cnt_t c, input logic [15:0] iv,
                                   input logic [15:0] add);
    cnt_t n;
    logic long_per;
    logic last;
    long_per = (add != 16'd0) && (c.per >= add - 16'd1);
    last     = long_per ? (c.pos >= iv) : (c.pos >= iv - 16'd1);
    n.pos    = last ? 16'd0 : c.pos + 16'd1;
    if (!last)
      n.per = c.per;
    else if (add == 16'd0 || long_per)
      n.per = 16'd0;
    else
      n.per = c.per + 16'd1;
    return n;
  endfunction

  function automatic logic in_window(input cnt_t c, input logic [15:0] skip,
                                     input logic [15:0] iv);
    return (iv != 16'd0) && (c.pos < skip);
  endfunction

  // A start of frame is also the start of line 0 and pixel 0
  assign px_cur  = beat_i.sof ? '0 : px_q;
  assign ln_cur  = beat_i.sof ? '0 : ln_q;
  assign px_drop = in_window(px_cur, cfg_i.px_to_skip, cfg_i.px_skip_interval);
  assign ln_drop = in_window(ln_cur, cfg_i.ln_to_skip, cfg_i.ln_skip_interval);
  assign xfer    = valid_i && ready_i;

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      px_q <= '0;
      ln_q <= '0;
    end
    else if (xfer)
    begin
      if (beat_i.eol)
      begin
        px_q <= '0;
        ln_q <= advance(ln_cur, cfg_i.ln_skip_interval, cfg_i.add_ln_skip_interval);
      end
      else
      begin
        px_q <= advance(px_cur, cfg_i.px_skip_interval, cfg_i.add_px_skip_interval);
        ln_q <= ln_cur;
      end
    end

  assign keep_o  = !(px_drop || ln_drop);
  assign beat_o  = beat_i;
  assign valid_o = valid_i;
  assign ready_o = ready_i;

endmodule

// ==== source/px_ss_top.sv ====
module px_ss_top #(
  parameter logic [31:0] BASE_ADDR = 32'h0000_0000
)(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  px_ss_pkg::axil_req_t csr_req_i,
  output px_ss_pkg::axil_rsp_t csr_rsp_o,
  input  px_ss_pkg::px_beat_t  in_beat_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  output px_ss_pkg::px_beat_t  out_beat_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);
  import px_ss_pkg::*;

  px_ss_cfg_t cfg;
  px_beat_t   in_beat;
  px_beat_t   skip_beat;
  logic       in_valid;
  logic       in_ready;
  logic       skip_valid;
  logic       skip_ready;
  logic       skip_keep;

  px_ss_csr #(
    .BASE_ADDR ( BASE_ADDR )
  ) i_px_ss_csr (
    .clk_i     ( clk_i     ),
    .rst_i     ( rst_i     ),
    .csr_req_i ( csr_req_i ),
    .csr_rsp_o ( csr_rsp_o ),
    .cfg_o     ( cfg       )
  );

  px_ss_in i_px_ss_in (
    .clk_i      ( clk_i      ),
    .rst_i      ( rst_i      ),
    .in_beat_i  ( in_beat_i  ),
    .in_valid_i ( in_valid_i ),
    .in_ready_o ( in_ready_o ),
    .beat_o     ( in_beat    ),
    .valid_o    ( in_valid   ),
    .ready_i    ( in_ready   )
  );

  px_ss_skip i_px_ss_skip (
    .clk_i   ( clk_i      ),
    .rst_i   ( rst_i      ),
    .cfg_i   ( cfg        ),
    .beat_i  ( in_beat    ),
    .valid_i ( in_valid   ),
    .ready_o ( in_ready   ),
    .beat_o  ( skip_beat  ),
    .keep_o  ( skip_keep  ),
    .valid_o ( skip_valid ),
    .ready_i ( skip_ready )
  );

  px_ss_out i_px_ss_out (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .beat_i      ( skip_beat   ),
    .keep_i      ( skip_keep   ),
    .valid_i     ( skip_valid  ),
    .ready_o     ( skip_ready  ),
    .out_beat_o  ( out_beat_o  ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i )
  );

endmodule

// ==== tests/tb_px_ss.sv ====
`include "px_ss_config.svh"

module tb_px_ss;
  import px_ss_pkg::*;

  typedef px_beat_t beat_q_t[$];

  localparam logic [31:0] CSR_BASE   = 32'h0000_0040;
  localparam int          WAIT_LIMIT = 1000;

  logic                  clk_i;
  logic                  rst_i;
  axil_req_t             csr_req;
  axil_rsp_t             csr_rsp;
  px_beat_t              in_beat_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  px_beat_t              out_beat_o;
  logic                  out_valid_o;
  logic                  out_ready_i;

  logic                  bp_en;
  logic [15:0]           px_lfsr;
  logic [15:0]           rdy_lfsr;
  logic [15:0]           shadow [0:5]; // Expected register contents
  logic [`PX_DATA_W-1:0] frame_px [0:255];
  beat_q_t               exp_q;
  px_beat_t              exp_b;
  int                    checks;
  int                    errors;
  int                    timeouts;

  px_ss_top #(
    .BASE_ADDR ( CSR_BASE )
  ) i_px_ss_top (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .csr_req_i   ( csr_req     ),
    .csr_rsp_o   ( csr_rsp     ),
    .in_beat_i   ( in_beat_i   ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .out_beat_o  ( out_beat_o  ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i )
  );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11, new bit enters at the bottom
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [`PX_DATA_W-1:0] next_pixel();
    logic [`PX_DATA_W-1:0] d;
    d = '0;
    for (int i = 0; i < `PX_DATA_W; i++)
    begin
      px_lfsr = lfsr_next(px_lfsr);
      d       = {d[`PX_DATA_W-2:0], px_lfsr[0]};
    end
    return d;
  endfunction

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // ====================
  // Reference model
  // ====================

  function automatic logic skip_hit(input int pos, input logic [15:0] skip,
                                    input logic [15:0] iv);
    return (iv != 16'd0) && (pos < int'(skip));
  endfunction

  // Every add-th period is one longer
  function automatic int period_len(input int per, input logic [15:0] iv,
                                    input logic [15:0] add);
    int len;
    len = int'(iv);
    if (add != 16'd0 && ((per + 1) % int'(add)) == 0)
      len++;
    return len;
  endfunction

  function automatic beat_q_t ref_subsample(input int w, input int h, input px_ss_cfg_t c);
    beat_q_t  q;
    px_beat_t b;
    int       ln_pos;
    int       ln_per;
    int       px_pos;
    int       px_per;
    int       last;
    logic     ln_keep;
    logic     first;
    first  = 1'b1;
    ln_pos = 0;
    ln_per = 0;
    for (int ln = 0; ln < h; ln++)
    begin
      ln_keep = !skip_hit(ln_pos, c.ln_to_skip, c.ln_skip_interval);
      px_pos  = 0;
      px_per  = 0;
      last    = -1;
      for (int px = 0; px < w; px++)
      begin
        if (ln_keep && !skip_hit(px_pos, c.px_to_skip, c.px_skip_interval))
        begin
          b.data = frame_px[8'(ln * w + px)];
          b.sof  = first;
          b.eol  = 1'b0;
          first  = 1'b0;
          q.push_back(b);
          last = q.size() - 1;
        end
        px_pos++;
        if (px_pos == period_len(px_per, c.px_skip_interval, c.add_px_skip_interval))
        begin
          px_pos = 0;
          px_per++;
        end
      end
      if (last >= 0)
      begin
        b       = q[last];
        b.eol   = 1'b1; // Last kept pixel closes the line
        q[last] = b;
      end
      ln_pos++;
      if (ln_pos == period_len(ln_per, c.ln_skip_interval, c.add_ln_skip_interval))
      begin
        ln_pos = 0;
        ln_per++;
      end
    end
    return q;
  endfunction

  function automatic px_ss_cfg_t shadow_cfg();
    px_ss_cfg_t c;
    c.px_to_skip           = shadow[PS_PX_SKIP_CR];
    c.px_skip_interval     = shadow[PS_PX_INTERVAL_CR];
    c.add_px_skip_interval = shadow[PS_PX_ADD_INTERVAL_CR];
    c.ln_to_skip           = shadow[PS_LN_SKIP_CR];
    c.ln_skip_interval     = shadow[PS_LN_INTERVAL_CR];
    c.add_ln_skip_interval = shadow[PS_LN_ADD_INTERVAL_CR];
    return c;
  endfunction

  // ====================
  // AXI4-Lite tasks
  // ====================

  task automatic axi_write(input csr_addr_e idx, input logic [31:0] data,
                           input logic [3:0] strb);
    logic aw_hit;
    logic w_hit;
    int   n;
    @(negedge clk_i);
    csr_req.awaddr  = CSR_BASE + 32'({idx, 2'b00});
    csr_req.awvalid = 1'b1;
    csr_req.wdata   = data;
    csr_req.wstrb   = strb;
    csr_req.wvalid  = 1'b1;
    csr_req.bready  = 1'b1;
    n = 0;
    while ((csr_req.awvalid || csr_req.wvalid) && n < WAIT_LIMIT)
    begin
      aw_hit = csr_req.awvalid && csr_rsp.awready;
      w_hit  = csr_req.wvalid && csr_rsp.wready;
      @(negedge clk_i);
      if (aw_hit)
        csr_req.awvalid = 1'b0;
      if (w_hit)
        csr_req.wvalid = 1'b0;
      n++;
    end
    if (csr_req.awvalid || csr_req.wvalid)
    begin
      timeouts++;
      $display("Timeout: write address or data to register %0d was never accepted", idx);
      csr_req.awvalid = 1'b0;
      csr_req.wvalid  = 1'b0;
    end
    n = 0;
    while (!csr_rsp.bvalid && n < WAIT_LIMIT)
    begin
      @(negedge clk_i);
      n++;
    end
    if (csr_rsp.bvalid)
      check_equal("write response", 32'(csr_rsp.bresp), 32'd0);
    else
    begin
      timeouts++;
      $display("Timeout: no write response for register %0d", idx);
    end
    @(negedge clk_i);
    csr_req.bready = 1'b0;
  endtask

  task automatic axi_read(input csr_addr_e idx, output logic [31:0] data);
    int n;
    @(negedge clk_i);
    csr_req.araddr  = CSR_BASE + 32'({idx, 2'b00});
    csr_req.arvalid = 1'b1;
    csr_req.rready  = 1'b1;
    n = 0;
    while (!csr_rsp.arready && n < WAIT_LIMIT)
    begin
      @(negedge clk_i);
      n++;
    end
    if (!csr_rsp.arready)
    begin
      timeouts++;
      $display("Timeout: read address for register %0d was never accepted", idx);
    end
    @(negedge clk_i);
    csr_req.arvalid = 1'b0;
    n = 0;
    while (!csr_rsp.rvalid && n < WAIT_LIMIT)
    begin
      @(negedge clk_i);
      n++;
    end
    if (csr_rsp.rvalid)
    begin
      data = csr_rsp.rdata;
      check_equal("read response", 32'(csr_rsp.rresp), 32'd0);
    end
    else
    begin
      timeouts++;
      $display("Timeout: no read data for register %0d", idx);
      data = 32'hFFFF_FFFF;
    end
    @(negedge clk_i);
    csr_req.rready = 1'b0;
  endtask

  task automatic write_reg(input csr_addr_e idx, input logic [31:0] data,
                           input logic [3:0] strb);
    axi_write(idx, data, strb);
    if (strb[0])
      shadow[idx][7:0] = data[7:0];
    if (strb[1])
      shadow[idx][15:8] = data[15:8];
  endtask

  task automatic check_all_regs(input string what);
    logic [31:0] rd;
    for (int i = 0; i < 6; i++)
    begin
      axi_read(csr_addr_e'(i), rd);
      check_equal(what, rd, {16'd0, shadow[i]});
    end
  endtask

  // ====================
  // Stream tasks
  // ====================

  // Called on a falling edge, returns one falling edge after the transfer
  task automatic send_beat(input px_beat_t b);
    int n;
    in_beat_i  = b;
    in_valid_i = 1'b1;
    n = 0;
    while (!in_ready_o && n < WAIT_LIMIT)
    begin
      @(negedge clk_i);
      n++;
    end
    if (!in_ready_o)
    begin
      timeouts++;
      $display("Timeout: input stream never became ready");
    end
    @(negedge clk_i);
  endtask

  task automatic send_frame(input int w, input int h);
    beat_q_t  exp_beats;
    px_beat_t b;
    for (int i = 0; i < w * h; i++)
      frame_px[8'(i)] = next_pixel();
    exp_beats = ref_subsample(w, h, shadow_cfg());
    foreach (exp_beats[i])
      exp_q.push_back(exp_beats[i]);
    @(negedge clk_i);
    for (int ln = 0; ln < h; ln++)
      for (int px = 0; px < w; px++)
      begin
        b.data = frame_px[8'(ln * w + px)];
        b.sof  = (ln == 0) && (px == 0);
        b.eol  = (px == w - 1);
        send_beat(b);
      end
    in_valid_i = 1'b0;
  endtask

  task automatic drain_output();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 4 * WAIT_LIMIT)
    begin
      @(negedge clk_i);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      timeouts++;
      $display("Timeout: %0d expected output beats never arrived", exp_q.size());
      exp_q.delete();
    end
    repeat (10) @(negedge clk_i); // Room for any extra beat to show up
  endtask

  // Output back-pressure
  initial
  begin
    rdy_lfsr    = 16'd51567;
    out_ready_i = 1'b1;
    forever
    begin
      @(negedge clk_i);
      if (bp_en)
      begin
        rdy_lfsr    = lfsr_next(rdy_lfsr);
        out_ready_i = rdy_lfsr[0];
      end
      else
        out_ready_i = 1'b1;
    end
  end

  always @(posedge clk_i)
    if (!rst_i && out_valid_o && out_ready_i)
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("Unexpected output beat %h at time %0t with nothing left to expect",
                 out_beat_o, $time);
      end
      else
      begin
        exp_b = exp_q.pop_front();
        check_equal("output beat", {6'd0, out_beat_o}, {6'd0, exp_b});
      end
    end

  // ====================
  // Main sequence
  // ====================

  initial
  begin
    rst_i      = 1'b1;
    csr_req    = '0;
    in_beat_i  = '0;
    in_valid_i = 1'b0;
    bp_en      = 1'b0;
    px_lfsr    = 16'd51567;
    checks     = 0;
    errors     = 0;
    timeouts   = 0;
    for (int i = 0; i < 6; i++)
      shadow[i] = 16'd0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    check_equal("input ready after reset", 32'(in_ready_o), 32'd1);
    check_all_regs("reset value");
    send_frame(8, 4); // Pass-through
    drain_output();

    for (int i = 0; i < 6; i++)
    begin
      write_reg(csr_addr_e'(i), 32'h1357_9BDF + 32'(i), 4'b0011);
      write_reg(csr_addr_e'(i), 32'h0000_6C6C + 32'(i * 3), i[0] ? 4'b0010 : 4'b0001);
      write_reg(csr_addr_e'(i), 32'hFFFF_FFFF, 4'b1100); // Upper lanes do not exist
    end
    check_all_regs("partial write readback");
    for (int i = 0; i < 6; i++)
      write_reg(csr_addr_e'(i), 32'd0, 4'b1111);

    write_reg(PS_PX_SKIP_CR, 32'd1, 4'b1111);
    write_reg(PS_PX_INTERVAL_CR, 32'd3, 4'b1111);
    write_reg(PS_PX_ADD_INTERVAL_CR, 32'd2, 4'b1111);
    send_frame(16, 3);
    drain_output();

    write_reg(PS_LN_SKIP_CR, 32'd2, 4'b1111);
    write_reg(PS_LN_INTERVAL_CR, 32'd3, 4'b1111);
    send_frame(12, 8);
    drain_output();

    write_reg(PS_LN_ADD_INTERVAL_CR, 32'd2, 4'b1111);
    check_all_regs("config readback");
    bp_en = 1'b1;
    send_frame(10, 6);
    send_frame(10, 6);
    drain_output();
    bp_en = 1'b0;

    $display("Checks: %0d  Errors: %0d  Timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule
